// ==== verilog/lc3b_types_pkg.sv ====
package lc3b_types_pkg;

	// data path and address
	typedef logic [15:0] lc3b_word;

	// register index
	typedef logic [2:0] lc3b_reg;

	// condition code, bit 2 is n and bit 0 is p
	typedef logic [2:0] lc3b_nzp;

	// immediate fields of the instruction word
	typedef logic [4:0] lc3b_imm5;
	typedef logic [5:0] lc3b_offset6;
	typedef logic [8:0] lc3b_offset9;

	// opcodes kept in this core, anything else retires as a no-op
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

endpackage : lc3b_types_pkg

// ==== verilog/lc3b_ctrl_pkg.sv ====
package lc3b_ctrl_pkg;

	import lc3b_types_pkg::*;

	// execute stage sequencing
	typedef enum logic [1:0] {
		ex_idle,
		ex_run,
		ex_mem_wait
	} ex_state_t;

	// owner of the memory port
	typedef enum logic [1:0] {
		arb_idle,
		arb_ifetch,
		arb_data
	} arb_state_t;

	// first fetch address
	localparam lc3b_word pc_reset = 16'h0000;

	// zero flag only
	localparam lc3b_nzp cc_reset = 3'b010;

	localparam int num_regs = 8;

endpackage : lc3b_ctrl_pkg

// ==== verilog/fetch.sv ====
module fetch
	import lc3b_types_pkg::*, lc3b_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic ir_take,
	input logic br_taken,
	input lc3b_word br_target,

	input logic if_resp,
	input lc3b_word if_rdata,
	output logic if_read,
	output lc3b_word if_address,

	output lc3b_word ir,
	output lc3b_word npc,
	output logic ir_valid
);

lc3b_word pc;
lc3b_word pc_next;
lc3b_word drop_addr;
lc3b_word q_ir [2];
lc3b_word q_npc [2];
logic [1:0] count;
logic discard;
logic req_on;
logic push;
logic pop;
logic wr_slot;

assign pc_next = pc + 16'd2;

// a dropped read keeps its old address until the memory answers
assign if_read = req_on && (discard || count != 2'd2);
assign if_address = discard ? drop_addr : pc;

assign push = if_resp && !discard && !br_taken;
assign pop = ir_take && !br_taken;

// slot the new word lands in once the head has been popped
assign wr_slot = count[0] ^ pop;

assign ir = q_ir[0];
assign npc = q_npc[0];
assign ir_valid = (count != 2'd0);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		pc <= pc_reset;
		count <= 2'd0;
		discard <= 1'b0;
		req_on <= 1'b0;
	end else begin
		req_on <= 1'b1;
		if (br_taken) begin
			pc <= br_target;
			count <= 2'd0;
			discard <= if_read && !if_resp;
		end else begin
			if (if_resp && discard)
				discard <= 1'b0;
			if (push)
				pc <= pc_next;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end
end

always_ff @(posedge clk) begin
	if (br_taken)
		drop_addr <= if_address;
	if (pop) begin
		q_ir[0] <= q_ir[1];
		q_npc[0] <= q_npc[1];
	end
	if (push) begin
		q_ir[wr_slot] <= if_rdata;
		q_npc[wr_slot] <= pc_next;
	end
end

a_if_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
	if_read && !if_resp |=> if_read && $stable(if_address));

endmodule : fetch

// ==== verilog/regfile.sv ====
module regfile
	import lc3b_types_pkg::*, lc3b_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input lc3b_reg sr1_idx,
	input lc3b_reg sr2_idx,
	input lc3b_reg wb_idx,
	input logic wb_en,
	input lc3b_word wb_data,

	output lc3b_word sr1_data,
	output lc3b_word sr2_data
);

lc3b_word regs [num_regs];

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int i = 0; i < num_regs; i++)
			regs[i] <= '0;
	end else if (wb_en) begin
		regs[wb_idx] <= wb_data;
	end
end

// reads see the old value during a write cycle
assign sr1_data = regs[sr1_idx];
assign sr2_data = regs[sr2_idx];

endmodule : regfile

// ==== verilog/execute_mem.sv ====
module execute_mem
	import lc3b_types_pkg::*, lc3b_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input lc3b_word ir,
	input lc3b_word npc,
	input logic ir_valid,
	output logic ir_take,

	input lc3b_word sr1_data,
	input lc3b_word sr2_data,
	output lc3b_reg sr1_idx,
	output lc3b_reg sr2_idx,
	output lc3b_reg wb_idx,
	output logic wb_en,
	output lc3b_word wb_data,

	output logic br_taken,
	output lc3b_word br_target,

	output logic d_read,
	output logic d_write,
	output lc3b_word d_address,
	output lc3b_word d_wdata,
	input logic d_resp,
	input lc3b_word d_rdata
);

ex_state_t state;
ex_state_t next_state;
lc3b_word cur_ir;
lc3b_word cur_npc;
lc3b_nzp cc;
lc3b_nzp br_nzp;
lc3b_opcode opcode;
lc3b_imm5 imm5;
lc3b_offset6 off6;
lc3b_offset9 off9;
lc3b_word operand2;
lc3b_word alu_out;

assign opcode = lc3b_opcode'(cur_ir[15:12]);
assign br_nzp = cur_ir[11:9];
assign imm5 = cur_ir[4:0];
assign off6 = cur_ir[5:0];
assign off9 = cur_ir[8:0];

assign wb_idx = cur_ir[11:9];
assign sr1_idx = cur_ir[8:6];
// STR reads its source through the second port
assign sr2_idx = (opcode == op_str) ? cur_ir[11:9] : cur_ir[2:0];

assign operand2 = cur_ir[5] ? {{11{imm5[4]}}, imm5} : sr2_data;

always_comb begin
	case (opcode)
		op_add: alu_out = sr1_data + operand2;
		op_and: alu_out = sr1_data & operand2;
		op_not: alu_out = ~sr1_data;
		default: alu_out = '0;
	endcase
end

// base plus offset in words
assign d_address = sr1_data + {{9{off6[5]}}, off6, 1'b0};
assign d_wdata = sr2_data;
assign br_target = cur_npc + {{6{off9[8]}}, off9, 1'b0};

always_comb begin
	next_state = state;
	ir_take = 1'b0;
	wb_en = 1'b0;
	wb_data = alu_out;
	br_taken = 1'b0;
	d_read = 1'b0;
	d_write = 1'b0;
	case (state)
		ex_idle: begin
			if (ir_valid) begin
				ir_take = 1'b1;
				next_state = ex_run;
			end
		end
		ex_run: begin
			next_state = ex_idle;
			case (opcode)
				op_add, op_and, op_not: wb_en = 1'b1;
				op_br: br_taken = |(br_nzp & cc);
				op_ldr, op_str: next_state = ex_mem_wait;
				default: ;
			endcase
		end
		ex_mem_wait: begin
			d_read = (opcode == op_ldr);
			d_write = (opcode == op_str);
			if (d_resp) begin
				wb_en = (opcode == op_ldr);
				wb_data = d_rdata;
				next_state = ex_idle;
			end
		end
		default: next_state = ex_idle;
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= ex_idle;
		cc <= cc_reset;
	end else begin
		state <= next_state;
		if (wb_en)
			cc <= {wb_data[15], wb_data == 16'h0000, !wb_data[15] && wb_data != 16'h0000};
	end
end

always_ff @(posedge clk) begin
	if (ir_take) begin
		cur_ir <= ir;
		cur_npc <= npc;
	end
end

// data request held until the memory answers
a_d_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
	(d_read || d_write) && !d_resp |=> $stable({d_read, d_write, d_address, d_wdata}));

endmodule : execute_mem

// ==== verilog/mem_arbiter.sv ====
module mem_arbiter
	import lc3b_types_pkg::*, lc3b_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic if_read,
	input lc3b_word if_address,
	output logic if_resp,
	output lc3b_word if_rdata,

	input logic d_read,
	input logic d_write,
	input lc3b_word d_address,
	input lc3b_word d_wdata,
	output logic d_resp,
	output lc3b_word d_rdata,

	output logic pmem_read,
	output logic pmem_write,
	output lc3b_word pmem_address,
	output lc3b_word pmem_wdata,
	input logic pmem_resp,
	input lc3b_word pmem_rdata
);

arb_state_t state;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= arb_idle;
	end else begin
		case (state)
			arb_idle: begin
				// data side wins a tie
				if (d_read || d_write)
					state <= arb_data;
				else if (if_read)
					state <= arb_ifetch;
			end
			arb_ifetch, arb_data: begin
				if (pmem_resp)
					state <= arb_idle;
			end
			default: state <= arb_idle;
		endcase
	end
end

assign pmem_read = (state == arb_data) ? d_read : (state == arb_ifetch) && if_read;
assign pmem_write = (state == arb_data) && d_write;
assign pmem_address = (state == arb_data) ? d_address : if_address;
assign pmem_wdata = d_wdata;

assign if_resp = (state == arb_ifetch) && pmem_resp;
assign d_resp = (state == arb_data) && pmem_resp;
assign if_rdata = pmem_rdata;
assign d_rdata = pmem_rdata;

// every memory answer goes to exactly one owner
a_resp_one_side: assert property (@(posedge clk) disable iff (!rst_n)
	pmem_resp |-> (if_resp != d_resp));

endmodule : mem_arbiter

// ==== verilog/cpu_top.sv ====
module cpu_top
	import lc3b_types_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic pmem_resp,
	input lc3b_word pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_word pmem_address,
	output lc3b_word pmem_wdata
);

// fetch to execute
lc3b_word ir;
lc3b_word npc;
logic ir_valid;
logic ir_take;
logic br_taken;
lc3b_word br_target;

// instruction side of the arbiter
logic if_read;
lc3b_word if_address;
logic if_resp;
lc3b_word if_rdata;

// register file ports
lc3b_reg sr1_idx;
lc3b_reg sr2_idx;
lc3b_reg wb_idx;
logic wb_en;
lc3b_word wb_data;
lc3b_word sr1_data;
lc3b_word sr2_data;

// data side of the arbiter
logic d_read;
logic d_write;
lc3b_word d_address;
lc3b_word d_wdata;
logic d_resp;
lc3b_word d_rdata;

fetch fetch_int
(
	.clk,
	.rst_n,
	.ir_take,
	.br_taken,
	.br_target,
	.if_resp,
	.if_rdata,
	.if_read,
	.if_address,
	.ir,
	.npc,
	.ir_valid
);

regfile regfile_int
(
	.clk,
	.rst_n,
	.sr1_idx,
	.sr2_idx,
	.wb_idx,
	.wb_en,
	.wb_data,
	.sr1_data,
	.sr2_data
);

execute_mem execute_int
(
	.clk,
	.rst_n,
	.ir,
	.npc,
	.ir_valid,
	.ir_take,
	.sr1_data,
	.sr2_data,
	.sr1_idx,
	.sr2_idx,
	.wb_idx,
	.wb_en,
	.wb_data,
	.br_taken,
	.br_target,
	.d_read,
	.d_write,
	.d_address,
	.d_wdata,
	.d_resp,
	.d_rdata
);

mem_arbiter arbiter_int
(
	.clk,
	.rst_n,
	.if_read,
	.if_address,
	.if_resp,
	.if_rdata,
	.d_read,
	.d_write,
	.d_address,
	.d_wdata,
	.d_resp,
	.d_rdata,
	.pmem_read,
	.pmem_write,
	.pmem_address,
	.pmem_wdata,
	.pmem_resp,
	.pmem_rdata
);

endmodule : cpu_top

// ==== tb/clock_gen.sv ====
module clock_gen (
	output logic clk,
	output logic rst_n
);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

// released one time unit after the tenth rising edge
initial begin
	rst_n = 1'b0;
	repeat (10) @(posedge clk);
	#1;
	rst_n = 1'b1;
end

endmodule : clock_gen

// ==== tb/cpu_top_tb.sv ====
module cpu_top_tb
	import lc3b_types_pkg::*;
();

localparam int mem_words = 256;
localparam int prog_len = 25;
localparam int num_stores = 7;
localparam int store_timeout = 400;
localparam int quiet_cycles = 60;

logic clk;
logic rst_n;
logic pmem_resp;
lc3b_word pmem_rdata;
logic pmem_read;
logic pmem_write;
lc3b_word pmem_address;
lc3b_word pmem_wdata;

lc3b_word mem [mem_words];
logic [31:0] lcg_state;
lc3b_word got_addr [$];
lc3b_word got_data [$];
time got_time [$];
int tests_run;
int tests_failed;

// byte address in the upper half, word in the lower half
logic [31:0] prog_table [prog_len] = '{
	// R7 = 0x0100 from the pointer at 0x3e, then add/and/not with stores
	{16'h0000, 16'h6E1F}, {16'h0002, 16'h1227}, {16'h0004, 16'h143D},
	{16'h0006, 16'h1642}, {16'h0008, 16'h77C0}, {16'h000A, 16'h58AD},
	{16'h000C, 16'h5A81}, {16'h000E, 16'h79C1}, {16'h0010, 16'h7BC2},
	{16'h0012, 16'h9C7F}, {16'h0014, 16'h7DC3},
	// loads at positive and negative offsets
	{16'h0016, 16'h63DF}, {16'h0018, 16'h1465}, {16'h001A, 16'h75C4},
	{16'h001C, 16'h67FF},
	// BRz not taken, BRn taken over the marker store at 0x26
	{16'h001E, 16'h0401}, {16'h0020, 16'h77C5}, {16'h0022, 16'h18FF},
	{16'h0024, 16'h0801}, {16'h0026, 16'h73C6}, {16'h0028, 16'h79C7},
	{16'h002A, 16'h0FFF},
	// data pointer and load data
	{16'h003E, 16'h0100}, {16'h013E, 16'h1234}, {16'h00FE, 16'h8001}
};

// expected stores in order, address then data
logic [31:0] store_table [num_stores] = '{
	{16'h0100, 16'h0004}, {16'h0102, 16'h000D}, {16'h0104, 16'h0005},
	{16'h0106, 16'hFFF8}, {16'h0108, 16'h1239}, {16'h010A, 16'h8001},
	{16'h010E, 16'h8000}
};

clock_gen u_clock (
	.clk,
	.rst_n
);

cpu_top u_dut (
	.clk,
	.rst_n,
	.pmem_resp,
	.pmem_rdata,
	.pmem_read,
	.pmem_write,
	.pmem_address,
	.pmem_wdata
);

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// memory model, acts one time unit after each rising edge
initial begin
	int wait_left;
	bit busy;
	logic [7:0] idx;
	lc3b_word load_addr;
	pmem_resp = 1'b0;
	pmem_rdata = '0;
	lcg_state = 32'h19d6_5451;
	busy = 1'b0;
	wait_left = 0;
	// fill is a never-taken BR holding its own byte address
	for (int a = 0; a < mem_words; a++)
		mem[a] = {7'b0000000, 9'(2 * a)};
	for (int i = 0; i < prog_len; i++) begin
		load_addr = prog_table[i][31:16];
		mem[load_addr[8:1]] = prog_table[i][15:0];
	end
	forever begin
		@(posedge clk);
		#1;
		pmem_resp = 1'b0;
		if (pmem_read || pmem_write) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = int'((lcg_next() >> 16) % 32'd4);
			end
			if (wait_left == 0) begin
				idx = pmem_address[8:1];
				if (pmem_write) begin
					mem[idx] = pmem_wdata;
					got_addr.push_back(pmem_address);
					got_data.push_back(pmem_wdata);
					got_time.push_back($time);
				end else begin
					pmem_rdata = mem[idx];
				end
				pmem_resp = 1'b1;
				busy = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end
end

task automatic tally(input string name, input bit ok);
	tests_run++;
	if (ok) begin
		$display("%s: pass", name);
	end else begin
		tests_failed++;
		$display("%s: FAIL", name);
	end
endtask

task automatic check_reset(output bit ok);
	int cycles;
	ok = 1'b1;
	cycles = 0;
	// also covers the first cycle after release
	do begin
		@(negedge clk);
		cycles++;
		assert (!pmem_read && !pmem_write) else begin
			$display("memory request at %0t while reset is active or just released", $time);
			ok = 1'b0;
		end
	end while (!rst_n && cycles < 40);
	if (!rst_n) begin
		$display("reset still active after %0d cycles", cycles);
		ok = 1'b0;
		return;
	end
	cycles = 0;
	while (!pmem_read && !pmem_write && cycles < 20) begin
		@(negedge clk);
		cycles++;
	end
	if (!pmem_read && !pmem_write) begin
		$display("no memory request within 20 cycles after reset");
		ok = 1'b0;
	end else begin
		assert (pmem_read && !pmem_write && pmem_address == 16'h0000) else begin
			$display("mismatch at %0t: first request rd %b wr %b addr %h, expected read at 0",
				$time, pmem_read, pmem_write, pmem_address);
			ok = 1'b0;
		end
	end
endtask

task automatic check_store(input int n, output bit ok, output bit lost);
	int cycles;
	ok = 1'b1;
	lost = 1'b0;
	cycles = 0;
	while (got_addr.size() <= n && cycles < store_timeout) begin
		@(negedge clk);
		cycles++;
	end
	if (got_addr.size() <= n) begin
		$display("store %0d did not arrive within %0d cycles", n, store_timeout);
		ok = 1'b0;
		lost = 1'b1;
	end else begin
		assert (got_addr[n] == store_table[n][31:16]) else begin
			$display("mismatch at %0t: store %0d to unexpected address %h, expected %h",
				got_time[n], n, got_addr[n], store_table[n][31:16]);
			ok = 1'b0;
		end
		assert (got_data[n] == store_table[n][15:0]) else begin
			$display("mismatch at %0t: store %0d wrote %h, expected %h",
				got_time[n], n, got_data[n], store_table[n][15:0]);
			ok = 1'b0;
		end
	end
endtask

task automatic check_quiet(output bit ok);
	int cycles;
	ok = 1'b1;
	cycles = 0;
	// program spins on its last branch by now
	while (cycles < quiet_cycles) begin
		@(negedge clk);
		cycles++;
	end
	assert (got_addr.size() == num_stores) else begin
		$display("%0d stores seen after the program finished, expected %0d",
			got_addr.size(), num_stores);
		ok = 1'b0;
	end
endtask

initial begin
	bit ok;
	bit lost;
	tests_run = 0;
	tests_failed = 0;
	lost = 1'b0;
	check_reset(ok);
	tally("reset", ok);
	for (int i = 0; i < num_stores && !lost; i++) begin
		check_store(i, ok, lost);
		tally($sformatf("store %0d", i), ok);
	end
	if (!lost) begin
		check_quiet(ok);
		tally("no extra stores", ok);
	end
	$display("%0d tests run, %0d passed, %0d failed",
		tests_run, tests_run - tests_failed, tests_failed);
	if (tests_failed == 0)
		$display("Test passed");
	else
		$display("Test failed");
	$finish;
end

endmodule : cpu_top_tb

// ==== files.f ====
verilog/lc3b_types_pkg.sv
verilog/lc3b_ctrl_pkg.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/execute_mem.sv
verilog/mem_arbiter.sv
verilog/cpu_top.sv
tb/clock_gen.sv
tb/cpu_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module cpu_top_tb -o cpu_top_sim

output=$(./obj_dir/cpu_top_sim)
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
